// ==== Makefile ====
# Verilator simulation of the switch ingress stage.

VERILATOR ?= verilator
TOP       ?= switch_tb
LOG       ?= sim.log
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f verilog.f
	$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== include/switch_cfg.svh ====
`ifndef SWITCH_CFG_SVH
`define SWITCH_CFG_SVH

// ---------------------------------------------------------------------------
// Switch ingress stage configuration
// ---------------------------------------------------------------------------

// Width of one packet word.
`define SW_DATA_W    16

// Payload words held per ingress port.
`define SW_BUF_DEPTH 64

// Index width into the port buffer, log2 of the depth.
`define SW_PTR_W     6

// Cycles from control word capture to the transfer request.
`define SW_CUT_DELAY 32

`endif

// ==== source/egress_arbiter.sv ====
`timescale 1ns/1ps

module egress_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_0,
    input  logic                  req_1,
    input  switch_pkg::pkt_desc_t desc_0,
    input  switch_pkg::pkt_desc_t desc_1,
    input  logic                  data_vld_0,
    input  logic                  data_vld_1,
    input  switch_pkg::data_t     data_0,
    input  switch_pkg::data_t     data_1,
    input  logic                  last_0,
    input  logic                  last_1,
    output logic                  xfer_stop_0,
    output logic                  xfer_stop_1,
    output logic                  out_new_packet,
    output switch_pkg::out_desc_t out_desc,
    output logic                  out_vld,
    output switch_pkg::data_t     out_data,
    output logic                  out_last
);

    import switch_pkg::*;

    arb_state_t state;
    logic       grant;       // Port being served.

    logic       pick_1;
    logic       start_pkt;
    logic       g_vld;
    logic       g_last;
    data_t      g_data;

    // -----------------------------------------------------------------------
    // Choice and grant mux
    // -----------------------------------------------------------------------

    // Port 0 wins on equal priority.
    assign pick_1 = req_1 && (!req_0 || (desc_1.prior > desc_0.prior));

    assign start_pkt = (state == ARB_IDLE) && (req_0 || req_1);

    assign g_vld  = grant ? data_vld_1 : data_vld_0;
    assign g_last = grant ? last_1     : last_0;
    assign g_data = grant ? data_1     : data_0;

    // -----------------------------------------------------------------------
    // Arbiter FSM
    // -----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= ARB_IDLE;
            grant          <= 1'b0;
            xfer_stop_0    <= 1'b1;
            xfer_stop_1    <= 1'b1;
            out_new_packet <= 1'b0;
            out_vld        <= 1'b0;
            out_last       <= 1'b0;
        end else begin
            out_new_packet <= 1'b0;
            out_vld        <= 1'b0;
            out_last       <= 1'b0;
            case (state)
                ARB_IDLE: begin
                    if (start_pkt) begin
                        state          <= ARB_BUSY;
                        grant          <= pick_1;
                        xfer_stop_0    <= pick_1;       // Loser keeps holding.
                        xfer_stop_1    <= !pick_1;
                        out_new_packet <= 1'b1;
                    end
                end

                ARB_BUSY: begin
                    out_vld  <= g_vld;
                    out_last <= g_vld && g_last;
                    // Release one cycle after the final word went out.
                    if (out_last) begin
                        state       <= ARB_IDLE;
                        xfer_stop_0 <= 1'b1;
                        xfer_stop_1 <= 1'b1;
                    end
                end

                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    // -----------------------------------------------------------------------
    // Output payload registers
    // -----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (start_pkt) begin
            out_desc.desc     <= pick_1 ? desc_1 : desc_0;
            out_desc.src_port <= pick_1;
        end
        if (g_vld) begin
            out_data <= g_data;
        end
    end

endmodule

// ==== source/ingress_port.sv ====
`timescale 1ns/1ps
`include "switch_cfg.svh"

module ingress_port (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_sop,
    input  logic                  wr_eop,
    input  logic                  wr_vld,
    input  switch_pkg::data_t     wr_data,
    input  logic                  xfer_stop,
    output logic                  req,
    output switch_pkg::pkt_desc_t desc,
    output logic                  data_vld,
    output switch_pkg::data_t     data,
    output logic                  last
);

    import switch_pkg::*;

    data_t       mem [`SW_BUF_DEPTH];
    buf_ptr_t    wr_ptr;
    buf_ptr_t    rd_ptr;
    logic        wr_open;        // Payload words of the current packet still arriving.

    port_state_t state;
    delay_cnt_t  delay_cnt;
    pkt_len_t    remain;         // Words left to send.

    pkt_desc_t   hdr;
    logic        hdr_take;
    logic        rd_take;

    assign hdr      = pkt_desc_t'(wr_data);
    assign hdr_take = (state == PORT_HEADER) && wr_vld;

    // Buffer is empty when the pointers meet; a packet never wraps onto itself.
    assign rd_take  = (state == PORT_XFER) && !xfer_stop && (rd_ptr != wr_ptr);

    assign req = (state == PORT_REQ);

    // -----------------------------------------------------------------------
    // Write side
    // -----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (wr_vld && wr_open) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            wr_open <= 1'b0;
        end else begin
            if (hdr_take) begin
                wr_open <= 1'b1;
            end else if (wr_vld && wr_eop) begin
                wr_open <= 1'b0;   // Last payload word closes the packet.
            end
            if (wr_vld && wr_open) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // Control word is held for the arbiter until the grant.
    always_ff @(posedge clk) begin
        if (hdr_take) begin
            desc <= hdr;
        end
    end

    // -----------------------------------------------------------------------
    // Port FSM: header capture, cut-through delay, request, transfer
    // -----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= PORT_IDLE;
            delay_cnt <= '0;
            remain    <= '0;
            rd_ptr    <= '0;
            data_vld  <= 1'b0;
            last      <= 1'b0;
        end else begin
            data_vld <= 1'b0;
            last     <= 1'b0;
            case (state)
                PORT_IDLE: begin
                    if (wr_sop) begin
                        state <= PORT_HEADER;
                    end
                end

                PORT_HEADER: begin
                    if (wr_vld) begin
                        state     <= PORT_DELAY;
                        delay_cnt <= '0;
                        remain    <= hdr.length;
                    end
                end

                PORT_DELAY: begin
                    delay_cnt <= delay_cnt + 1'b1;
                    if (delay_cnt == delay_cnt_t'(`SW_CUT_DELAY - 1)) begin
                        state <= PORT_REQ;   // Request rises SW_CUT_DELAY after capture.
                    end
                end

                PORT_REQ: begin
                    if (!xfer_stop) begin
                        state <= PORT_XFER;
                    end
                end

                PORT_XFER: begin
                    if (rd_take) begin
                        data_vld <= 1'b1;
                        rd_ptr   <= rd_ptr + 1'b1;
                        remain   <= remain - 1'b1;
                        if (remain == pkt_len_t'(1)) begin
                            last  <= 1'b1;
                            state <= PORT_IDLE;
                        end
                    end
                end

                default: begin
                    state <= PORT_IDLE;
                end
            endcase
        end
    end

    // Read data path.
    always_ff @(posedge clk) begin
        if (rd_take) begin
            data <= mem[rd_ptr];
        end
    end

endmodule

// ==== source/switch_pkg.sv ====
`include "switch_cfg.svh"

package switch_pkg;

    typedef logic [`SW_DATA_W-1:0] data_t;
    typedef logic [3:0]            dest_t;
    typedef logic [2:0]            prior_t;      // Larger value wins.
    typedef logic [8:0]            pkt_len_t;    // Payload words, control word excluded.
    typedef logic [`SW_PTR_W-1:0]  buf_ptr_t;
    typedef logic [5:0]            delay_cnt_t;

    // -----------------------------------------------------------------------
    // Descriptors
    // -----------------------------------------------------------------------

    // Same bit layout as the control word on the write side.
    typedef struct packed {
        pkt_len_t length;    // Bits 15:7.
        prior_t   prior;     // Bits 6:4.
        dest_t    dest;      // Bits 3:0.
    } pkt_desc_t;

    typedef struct packed {
        pkt_desc_t desc;
        logic      src_port;
    } out_desc_t;

    // -----------------------------------------------------------------------
    // State machines
    // -----------------------------------------------------------------------

    typedef enum logic [2:0] {
        PORT_IDLE,
        PORT_HEADER,
        PORT_DELAY,
        PORT_REQ,
        PORT_XFER
    } port_state_t;

    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_t;

endpackage

// ==== source/switch_top.sv ====
`timescale 1ns/1ps

module switch_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_sop_0,
    input  logic                  wr_eop_0,
    input  logic                  wr_vld_0,
    input  switch_pkg::data_t     wr_data_0,
    input  logic                  wr_sop_1,
    input  logic                  wr_eop_1,
    input  logic                  wr_vld_1,
    input  switch_pkg::data_t     wr_data_1,
    output logic                  out_new_packet,
    output switch_pkg::out_desc_t out_desc,
    output logic                  out_vld,
    output switch_pkg::data_t     out_data,
    output logic                  out_last
);

    import switch_pkg::*;

    logic      req_0;
    logic      req_1;
    pkt_desc_t desc_0;
    pkt_desc_t desc_1;
    logic      data_vld_0;
    logic      data_vld_1;
    data_t     data_0;
    data_t     data_1;
    logic      last_0;
    logic      last_1;
    logic      xfer_stop_0;
    logic      xfer_stop_1;

    // -----------------------------------------------------------------------
    // Ingress ports
    // -----------------------------------------------------------------------

    ingress_port port0_inst (
        .clk       (clk),
        .rst       (rst),
        .wr_sop    (wr_sop_0),
        .wr_eop    (wr_eop_0),
        .wr_vld    (wr_vld_0),
        .wr_data   (wr_data_0),
        .xfer_stop (xfer_stop_0),
        .req       (req_0),
        .desc      (desc_0),
        .data_vld  (data_vld_0),
        .data      (data_0),
        .last      (last_0)
    );

    ingress_port port1_inst (
        .clk       (clk),
        .rst       (rst),
        .wr_sop    (wr_sop_1),
        .wr_eop    (wr_eop_1),
        .wr_vld    (wr_vld_1),
        .wr_data   (wr_data_1),
        .xfer_stop (xfer_stop_1),
        .req       (req_1),
        .desc      (desc_1),
        .data_vld  (data_vld_1),
        .data      (data_1),
        .last      (last_1)
    );

    // Single output, one packet at a time.
    egress_arbiter arb_inst (
        .clk            (clk),
        .rst            (rst),
        .req_0          (req_0),
        .req_1          (req_1),
        .desc_0         (desc_0),
        .desc_1         (desc_1),
        .data_vld_0     (data_vld_0),
        .data_vld_1     (data_vld_1),
        .data_0         (data_0),
        .data_1         (data_1),
        .last_0         (last_0),
        .last_1         (last_1),
        .xfer_stop_0    (xfer_stop_0),
        .xfer_stop_1    (xfer_stop_1),
        .out_new_packet (out_new_packet),
        .out_desc       (out_desc),
        .out_vld        (out_vld),
        .out_data       (out_data),
        .out_last       (out_last)
    );

endmodule

// ==== verif/switch_assert.sv ====
`timescale 1ns/1ps

module switch_assert (
    input logic                   clk,
    input logic                   rst,
    input switch_pkg::arb_state_t state,
    input logic                   xfer_stop_0,
    input logic                   xfer_stop_1,
    input logic                   out_vld,
    input logic                   out_new_packet
);

    import switch_pkg::*;

    // Only one port may move words at a time.
    one_port_open: assert property (@(posedge clk) disable iff (rst)
        xfer_stop_0 || xfer_stop_1)
        else $error("both xfer_stop levels are low");

    out_vld_busy: assert property (@(posedge clk) disable iff (rst)
        out_vld |-> (state == ARB_BUSY))
        else $error("out_vld outside ARB_BUSY");

    // Descriptor pulse never overlaps a payload word.
    new_pkt_alone: assert property (@(posedge clk) disable iff (rst)
        !(out_new_packet && out_vld))
        else $error("out_new_packet together with out_vld");

    stop_after_reset: assert property (@(posedge clk)
        rst |=> (xfer_stop_0 && xfer_stop_1))
        else $error("xfer_stop not held high after reset");

endmodule

bind egress_arbiter switch_assert switch_assert_inst (
    .clk            (clk),
    .rst            (rst),
    .state          (state),
    .xfer_stop_0    (xfer_stop_0),
    .xfer_stop_1    (xfer_stop_1),
    .out_vld        (out_vld),
    .out_new_packet (out_new_packet)
);

// ==== verif/switch_tb.sv ====
`timescale 1ns/1ps
`include "switch_cfg.svh"

module switch_tb;

    import switch_pkg::*;

    localparam int MAX_PKTS   = 64;
    localparam int MAX_WORDS  = 48;
    localparam int WAIT_LIMIT = 4000;

    logic      clk = 1'b0;
    logic      rst;
    logic      sop [2];
    logic      eop [2];
    logic      vld [2];
    data_t     wdata [2];
    logic      out_new_packet;
    out_desc_t out_desc;
    logic      out_vld;
    data_t     out_data;
    logic      out_last;

    // Packets as written.
    int        n_pkts;
    int        pk_port [MAX_PKTS];
    dest_t     pk_dest [MAX_PKTS];
    prior_t    pk_prior [MAX_PKTS];
    int        pk_len [MAX_PKTS];
    int        pk_gap [MAX_PKTS];
    int        pk_hdr_cycle [MAX_PKTS];    // Cycle in which the control word is driven.
    data_t     pk_word [MAX_PKTS][MAX_WORDS];
    int        pk_word_gap [MAX_PKTS][MAX_WORDS];
    logic      taken [MAX_PKTS];

    // Packets as seen on the output.
    int        rx_count;
    logic      rx_open;
    out_desc_t rx_desc [MAX_PKTS];
    int        rx_start [MAX_PKTS];
    int        rx_len [MAX_PKTS];
    data_t     rx_word [MAX_PKTS][MAX_WORDS];

    int        sent_by_port [2];
    int        rcvd_by_port [2];
    int        cycle;
    int        mismatches;
    int        other_errors;
    logic      abort;
    logic [15:0] lfsr;

    switch_top switch_top_inst (
        .clk            (clk),
        .rst            (rst),
        .wr_sop_0       (sop[0]),
        .wr_eop_0       (eop[0]),
        .wr_vld_0       (vld[0]),
        .wr_data_0      (wdata[0]),
        .wr_sop_1       (sop[1]),
        .wr_eop_1       (eop[1]),
        .wr_vld_1       (vld[1]),
        .wr_data_1      (wdata[1]),
        .out_new_packet (out_new_packet),
        .out_desc       (out_desc),
        .out_vld        (out_vld),
        .out_data       (out_data),
        .out_last       (out_last)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (rst) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------

    // Galois LFSR with taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int rand_bits(input int n);
        int val;
        int i;
        val = 0;
        for (i = 0; i < n; i++) begin
            val  = (val << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
        return val;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic report_timeout(input string what);
        $display("TIMEOUT: waited %0d cycles for %s", WAIT_LIMIT, what);
        other_errors++;
        abort = 1'b1;
    endtask

    // Negative prior, len or gap draws a random value.
    // Mode 1 adds rare word gaps and mode 2 many.
    task automatic add_packet(input int port, input int prior, input int len, input int gap,
                              input int mode);
        int w;
        pk_port[n_pkts]  = port;
        pk_dest[n_pkts]  = dest_t'(rand_bits(4));
        pk_prior[n_pkts] = prior_t'((prior < 0) ? rand_bits(3) : prior);
        pk_len[n_pkts]   = (len < 0) ? (rand_bits(6) % MAX_WORDS) + 1 : len;
        pk_gap[n_pkts]   = (gap < 0) ? rand_bits(4) : gap;
        taken[n_pkts]    = 1'b0;
        for (w = 0; w < pk_len[n_pkts]; w++) begin
            pk_word[n_pkts][w] = data_t'(rand_bits(16));
            if (mode == 2) begin
                pk_word_gap[n_pkts][w] = rand_bits(2);
            end else if (mode == 1) begin
                pk_word_gap[n_pkts][w] = (rand_bits(3) == 0) ? 1 : 0;
            end else begin
                pk_word_gap[n_pkts][w] = 0;
            end
        end
        n_pkts++;
    endtask

    task automatic send_packet(input int i);
        int p;
        int n;
        int w;
        p = pk_port[i];
        n = 0;
        // Next packet of a port only after its previous one has left.
        while (!abort && rcvd_by_port[p] != sent_by_port[p] && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!abort && rcvd_by_port[p] != sent_by_port[p]) begin
            report_timeout("the previous packet of a port to leave");
        end
        if (!abort) begin
            repeat (pk_gap[i]) next_cycle();
            sop[p] = 1'b1;
            next_cycle();
            sop[p]   = 1'b0;
            vld[p]   = 1'b1;
            wdata[p] = {pk_len[i][8:0], pk_prior[i], pk_dest[i]};   // Control word.
            pk_hdr_cycle[i] = cycle;
            sent_by_port[p]++;
            next_cycle();
            for (w = 0; w < pk_len[i]; w++) begin
                if (pk_word_gap[i][w] > 0) begin
                    vld[p] = 1'b0;
                    eop[p] = 1'b0;
                    repeat (pk_word_gap[i][w]) next_cycle();
                end
                vld[p]   = 1'b1;
                eop[p]   = (w == pk_len[i] - 1);
                wdata[p] = pk_word[i][w];
                next_cycle();
            end
            vld[p] = 1'b0;
            eop[p] = 1'b0;
        end
    endtask

    task automatic write_port(input int p, input int first, input int last);
        int i;
        for (i = first; i <= last; i++) begin
            if (pk_port[i] == p) begin
                send_packet(i);
            end
        end
    endtask

    // Both ports write side by side and then the output drains.
    task automatic run_packets(input int first, input int last);
        int n;
        fork
            write_port(0, first, last);
            write_port(1, first, last);
        join
        n = 0;
        while (!abort && rx_count < n_pkts && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!abort && rx_count < n_pkts) begin
            report_timeout("all packets to leave the switch");
        end
    endtask

    // ------------------------------------------------------------------------
    // Output monitor
    // ------------------------------------------------------------------------

    always @(negedge clk) begin
        if (!rst && rx_count < MAX_PKTS) begin
            if (out_new_packet) begin
                if (rx_open) begin
                    $display("out_new_packet came before the previous packet ended");
                    other_errors++;
                end
                rx_desc[rx_count]  = out_desc;
                rx_start[rx_count] = cycle;
                rx_len[rx_count]   = 0;
                rx_open            = 1'b1;
            end
            if (out_vld && !rx_open) begin
                $display("out_vld came outside a packet");
                other_errors++;
            end else if (out_vld && rx_len[rx_count] >= MAX_WORDS) begin
                $display("Output packet %0d runs past %0d words", rx_count, MAX_WORDS);
                other_errors++;
            end else if (out_vld) begin
                rx_word[rx_count][rx_len[rx_count]] = out_data;
                rx_len[rx_count]++;
            end
            if (out_last && !out_vld) begin
                $display("out_last came without out_vld");
                other_errors++;
            end
            if (out_last && rx_open) begin
                rcvd_by_port[rx_desc[rx_count].src_port]++;
                rx_count++;
                rx_open = 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Reference model and comparison
    // ------------------------------------------------------------------------

    function automatic int req_cycle(input int i);
        return pk_hdr_cycle[i] + 1 + `SW_CUT_DELAY;   // Header edge plus cut-through delay.
    endfunction

    // Earliest request first. In the same cycle the higher priority wins and then port 0.
    function automatic int next_expected();
        int best;
        int i;
        best = -1;
        for (i = 0; i < n_pkts; i++) begin
            if (!taken[i] && (best < 0 || req_cycle(i) < req_cycle(best) ||
                (req_cycle(i) == req_cycle(best) && (pk_prior[i] > pk_prior[best] ||
                (pk_prior[i] == pk_prior[best] && pk_port[i] < pk_port[best]))))) begin
                best = i;
            end
        end
        return best;
    endfunction

    task automatic compare(input string name, input int pkt, input logic [31:0] got,
                           input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s in output packet %0d: got 0x%0h, expected 0x%0h",
                     name, pkt, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_results();
        int k;
        int e;
        int w;
        if (rx_count != n_pkts) begin
            $display("Expected %0d packets on the output, saw %0d", n_pkts, rx_count);
            other_errors++;
        end
        for (k = 0; k < rx_count; k++) begin
            e = next_expected();
            if (e < 0) begin
                $display("Output packet %0d matches no packet that was sent", k);
                other_errors++;
            end else begin
                taken[e] = 1'b1;
                compare("out_desc", k, rx_desc[k],
                        {pk_len[e][8:0], pk_prior[e], pk_dest[e], pk_port[e][0]});
                compare("out_last position", k, rx_len[k], pk_len[e]);
                if (rx_start[k] < pk_hdr_cycle[e] + `SW_CUT_DELAY + 2) begin
                    $display("Output packet %0d started %0d cycles after its control word",
                             k, rx_start[k] - pk_hdr_cycle[e]);
                    other_errors++;
                end
                for (w = 0; w < pk_len[e] && w < rx_len[k]; w++) begin
                    compare("out_data", k, rx_word[k][w], pk_word[e][w]);
                end
            end
        end
    endtask

    initial begin
        int first;
        int i;
        lfsr         = 16'd85;
        n_pkts       = 0;
        rx_count     = 0;
        rx_open      = 1'b0;
        mismatches   = 0;
        other_errors = 0;
        abort        = 1'b0;
        for (i = 0; i < 2; i++) begin
            sop[i]          = 1'b0;
            eop[i]          = 1'b0;
            vld[i]          = 1'b0;
            wdata[i]        = '0;
            sent_by_port[i] = 0;
            rcvd_by_port[i] = 0;
        end
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        next_cycle();

        first = n_pkts;                     // Single packet on port 0.
        add_packet(0, -1, 12, 0, 0);
        run_packets(first, n_pkts - 1);

        first = n_pkts;                     // Port 1 outranks port 0 in one cycle.
        add_packet(0, 2, -1, 0, 0);
        add_packet(1, 6, -1, 0, 0);
        run_packets(first, n_pkts - 1);

        first = n_pkts;                     // Equal priorities in one cycle.
        add_packet(0, 5, -1, 0, 0);
        add_packet(1, 5, -1, 0, 0);
        run_packets(first, n_pkts - 1);

        first = n_pkts;                     // Slow writer that the transfer catches up with.
        add_packet(1, -1, MAX_WORDS, 0, 2);
        run_packets(first, n_pkts - 1);

        first = n_pkts;
        for (i = 0; i < 40; i++) begin
            add_packet(rand_bits(1), -1, -1, -1, 1);
        end
        run_packets(first, n_pkts - 1);

        check_results();
        $display("Checked %0d of %0d packets: %0d mismatches, %0d other errors",
                 rx_count, n_pkts, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
source/switch_pkg.sv
source/ingress_port.sv
source/egress_arbiter.sv
source/switch_top.sv
verif/switch_assert.sv
verif/switch_tb.sv
